// ==== fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// sv39 virtual address, one 64-bit memory word per fetch group
`define FETCH_VADDR_W 39
`define FETCH_WORD_W 64
`define FETCH_INST_W 32

// default start address after reset
`define FETCH_RESET_ADDR 39'h40_0000_0000

// rv major opcodes for control transfer
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111

// rvc quadrants and funct3 codes of the compressed jumps and branches
`define RVC_Q1 2'b01
`define RVC_Q2 2'b10
`define RVC_F3_J 3'b101
`define RVC_F3_JAL 3'b001
`define RVC_F3_BEQZ 3'b110
`define RVC_F3_BNEZ 3'b111
`define RVC_F3_JR 3'b100

`endif

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_ctrl #(
    parameter logic [`FETCH_VADDR_W-1:0] RESET_ADDR = `FETCH_RESET_ADDR
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_mem_valid,
    input  logic                      i_output_ready,
    input  logic                      i_output_valid,
    input  logic [1:0]                i_branch,
    input  logic [1:0]                i_compressed,
    input  logic                      i_branch_valid,
    input  logic [`FETCH_VADDR_W-1:0] i_branch_target,
    output logic                      o_mem_ren,
    output logic [`FETCH_VADDR_W-1:0] o_mem_raddr,
    output logic                      o_hold
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e next_state;
    fetch_pkg::fetch_state_e after_send;

    logic [`FETCH_VADDR_W-1:0] pc;
    logic [`FETCH_VADDR_W-1:0] next_pc;
    logic [3:0]                advance;
    logic                      sent;
    logic                      branched;

    // a group leaves when offered and decode takes it
    assign sent = i_output_valid && i_output_ready;
    assign branched = |i_branch;

    // after a send, stop for the resolved target if any slot jumps
    assign after_send = branched ? fetch_pkg::RESOL : fetch_pkg::FETCH;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= fetch_pkg::INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // first request goes out straight after reset
            fetch_pkg::INIT: next_state = fetch_pkg::FETCH;
            // request in flight, data may return this cycle
            fetch_pkg::FETCH: begin
                if (sent) begin
                    next_state = after_send;
                end else if (i_output_valid) begin
                    next_state = fetch_pkg::VALID;
                end else begin
                    next_state = fetch_pkg::CACHE;
                end
            end
            // memory still busy
            fetch_pkg::CACHE: begin
                if (i_mem_valid) begin
                    next_state = sent ? after_send : fetch_pkg::VALID;
                end
            end
            // group parked until decode is ready
            fetch_pkg::VALID: begin
                if (sent) begin
                    next_state = after_send;
                end
            end
            // wait for the branch unit
            fetch_pkg::RESOL: begin
                if (i_branch_valid) begin
                    next_state = fetch_pkg::FETCH;
                end
            end
            default: next_state = fetch_pkg::INIT;
        endcase
    end

    // bytes consumed by the issued slots
    // a branch in slot 0 stops the group after slot 0 itself
    always_comb begin
        casez ({i_branch[0], i_compressed})
            3'b000:  advance = 4'd8;
            3'b001,
            3'b010:  advance = 4'd6;
            3'b011:  advance = 4'd4;
            3'b1?0:  advance = 4'd4;
            default: advance = 4'd2;
        endcase
    end

    // target load only in RESOL, otherwise step on send
    always_comb begin
        next_pc = pc;
        if (state == fetch_pkg::RESOL) begin
            if (i_branch_valid) begin
                next_pc = i_branch_target;
            end
        end else if (sent) begin
            next_pc = pc + {{(`FETCH_VADDR_W-4){1'b0}}, advance};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

    // one request per entry into FETCH, at the group shown next
    assign o_mem_ren = i_rst_n && (next_state == fetch_pkg::FETCH);
    assign o_mem_raddr = next_pc;
    assign o_hold = state == fetch_pkg::VALID;

endmodule

// ==== fetch_hold.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_hold (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_mem_valid,
    input  logic                     i_hold,
    input  fetch_pkg::fetch_bundle_t i_live,
    output logic                     o_output_valid,
    output fetch_pkg::fetch_bundle_t o_bundle
);

    fetch_pkg::fetch_bundle_t held;

    // capture every returned group
    // only used if decode does not take it in the return cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            held <= '0;
        end else if (i_mem_valid) begin
            held <= i_live;
        end
    end

    // live data in the return cycle, stored copy while stalled on decode
    always_comb begin
        if (i_hold) begin
            o_bundle = held;
        end else begin
            o_bundle = i_live;
        end
    end

    // a group is on offer when memory just answered or one is parked
    assign o_output_valid = i_mem_valid || i_hold;

endmodule

// ==== fetch_pick.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_pick (
    input  logic [`FETCH_WORD_W-1:0] i_word,
    output fetch_pkg::inst_u         o_slot0,
    output fetch_pkg::inst_u         o_slot1,
    output logic [1:0]               o_compressed
);

    logic [`FETCH_INST_W-1:0] slot1_word;

    // slot 0 always starts at the bottom of the word
    assign o_slot0 = i_word[`FETCH_INST_W-1:0];

    // a 16-bit encoding has anything other than 2'b11 in its low bits
    assign o_compressed[0] = o_slot0.rvc.quadrant != 2'b11;

    // slot 1 follows slot 0 directly
    // halfword 1 after a compressed slot 0, else word 1
    always_comb begin
        if (o_compressed[0]) begin
            slot1_word = i_word[47:16];
        end else begin
            slot1_word = i_word[63:32];
        end
    end

    assign o_slot1 = slot1_word;

    // same length rule applied at the second start
    assign o_compressed[1] = o_slot1.rvc.quadrant != 2'b11;

endmodule

// ==== fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

    // full 32-bit encoding, only the major opcode matters to predecode
    typedef struct packed {
        logic [`FETCH_INST_W-8:0] upper;
        logic [6:0]               opcode;
    } inst_full_t;

    // compressed encoding sits in the low half of the slot
    // bit12 and rs1/rs2 split c.jr/c.jalr from c.mv/c.add/c.ebreak
    typedef struct packed {
        logic [15:0] unused;
        logic [2:0]  funct3;
        logic        bit12;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [1:0]  quadrant;
    } inst_rvc_t;

    // one slot word, read as full or compressed depending on its low bits
    typedef union packed {
        inst_full_t full;
        inst_rvc_t  rvc;
    } inst_u;

    // group handed to decode
    // compressed[0] belongs to inst0, compressed[1] to inst1
    // count high means both slots issue
    typedef struct packed {
        inst_u      inst0;
        inst_u      inst1;
        logic [1:0] compressed;
        logic       count;
    } fetch_bundle_t;

    typedef enum logic [2:0] {
        FETCH = 3'h0,
        CACHE = 3'h1,
        VALID = 3'h2,
        RESOL = 3'h3,
        INIT  = 3'h4
    } fetch_state_e;

endpackage

// ==== fetch_predecode.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_predecode (
    input  fetch_pkg::inst_u i_inst,
    input  logic             i_compressed,
    output logic             o_branch
);

    logic full_hit;
    logic rvc_q1_hit;
    logic rvc_q2_hit;

    // 32-bit view: conditional branches, jal and jalr
    assign full_hit = (i_inst.full.opcode == `OPC_BRANCH) ||
                      (i_inst.full.opcode == `OPC_JAL) ||
                      (i_inst.full.opcode == `OPC_JALR);

    // quadrant 1: c.j, c.jal, c.beqz, c.bnez
    always_comb begin
        rvc_q1_hit = 1'b0;
        if (i_inst.rvc.quadrant == `RVC_Q1) begin
            case (i_inst.rvc.funct3)
                `RVC_F3_J,
                `RVC_F3_JAL,
                `RVC_F3_BEQZ,
                `RVC_F3_BNEZ: rvc_q1_hit = 1'b1;
                default:      rvc_q1_hit = 1'b0;
            endcase
        end
    end

    // quadrant 2: c.jr and c.jalr share funct3 with c.mv/c.add
    // a jump has a nonzero rs1 and rs2 of zero
    // rs1 of zero with rs2 of zero would be c.ebreak
    assign rvc_q2_hit = (i_inst.rvc.quadrant == `RVC_Q2) &&
                        (i_inst.rvc.funct3 == `RVC_F3_JR) &&
                        (i_inst.rvc.rs1 != 5'd0) &&
                        (i_inst.rvc.rs2 == 5'd0);

    // pick the view that matches the slot length
    always_comb begin
        if (i_compressed) begin
            o_branch = rvc_q1_hit || rvc_q2_hit;
        end else begin
            o_branch = full_hit;
        end
    end

endmodule

// ==== fetch_props.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_props (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_mem_ren,
    input logic                     i_mem_valid,
    input logic                     i_output_ready,
    input logic                     i_output_valid,
    input fetch_pkg::fetch_bundle_t i_bundle
);

    int   fail_count = 0;
    logic outstanding;

    // one word requested and not yet answered
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            outstanding <= 1'b0;
        end else if (i_mem_ren) begin
            outstanding <= 1'b1;
        end else if (i_mem_valid) begin
            outstanding <= 1'b0;
        end
    end

    // quiet ports while reset is held
    reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_mem_ren && !i_output_valid)
        else begin
            fail_count++;
            $error("request or output valid seen during reset");
        end

    // a stalled group stays put until decode takes it
    hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_output_valid && !i_output_ready |=> i_output_valid && $stable(i_bundle))
        else begin
            fail_count++;
            $error("output group changed under back-pressure");
        end

    // next request only once the previous one is answered
    single_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem_ren && outstanding |-> i_mem_valid)
        else begin
            fail_count++;
            $error("second memory request while one is outstanding");
        end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_unit #(
    parameter logic [`FETCH_VADDR_W-1:0] RESET_ADDR = `FETCH_RESET_ADDR
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    output logic                      o_mem_ren,
    output logic [`FETCH_VADDR_W-1:0] o_mem_raddr,
    input  logic [`FETCH_WORD_W-1:0]  i_mem_rdata,
    input  logic                      i_mem_valid,
    input  logic [`FETCH_VADDR_W-1:0] i_branch_target,
    input  logic                      i_branch_valid,
    input  logic                      i_output_ready,
    output logic                      o_output_valid,
    output fetch_pkg::fetch_bundle_t  o_bundle
);

    fetch_pkg::inst_u         slot0;
    fetch_pkg::inst_u         slot1;
    fetch_pkg::fetch_bundle_t live;
    logic [1:0]               compressed;
    logic [1:0]               branch;
    logic                     hold;

    // split the returned word into two slots
    fetch_pick u_pick (
        .i_word       (i_mem_rdata),
        .o_slot0      (slot0),
        .o_slot1      (slot1),
        .o_compressed (compressed)
    );

    fetch_predecode u_predecode0 (
        .i_inst       (slot0),
        .i_compressed (compressed[0]),
        .o_branch     (branch[0])
    );

    fetch_predecode u_predecode1 (
        .i_inst       (slot1),
        .i_compressed (compressed[1]),
        .o_branch     (branch[1])
    );

    // no speculation past a slot 0 branch, so slot 1 is dropped then
    assign live.inst0 = slot0;
    assign live.inst1 = slot1;
    assign live.compressed = compressed;
    assign live.count = !branch[0];

    fetch_ctrl #(
        .RESET_ADDR (RESET_ADDR)
    ) u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_mem_valid     (i_mem_valid),
        .i_output_ready  (i_output_ready),
        .i_output_valid  (o_output_valid),
        .i_branch        (branch),
        .i_compressed    (compressed),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target),
        .o_mem_ren       (o_mem_ren),
        .o_mem_raddr     (o_mem_raddr),
        .o_hold          (hold)
    );

    fetch_hold u_hold (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_valid    (i_mem_valid),
        .i_hold         (hold),
        .i_live         (live),
        .o_output_valid (o_output_valid),
        .o_bundle       (o_bundle)
    );

endmodule

// ==== files.f ====
+incdir+.
fetch_pkg.sv
fetch_pick.sv
fetch_predecode.sv
fetch_hold.sv
fetch_ctrl.sv
fetch_unit.sv
fetch_props.sv
tb_fetch.sv

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module tb_fetch;

    localparam int N_GROUPS = 400;
    localparam int RESET_CYCLES = 8;
    localparam int CLK_PERIOD = 8;
    // worst memory latency, worst ready wait and branch wait per group
    localparam int GROUP_CYCLES = 4 + 4 + 8;
    localparam int WATCHDOG_NS = (RESET_CYCLES + N_GROUPS * GROUP_CYCLES) * CLK_PERIOD;

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      o_mem_ren;
    logic [`FETCH_VADDR_W-1:0] o_mem_raddr;
    logic [`FETCH_WORD_W-1:0]  i_mem_rdata;
    logic                      i_mem_valid;
    logic [`FETCH_VADDR_W-1:0] i_branch_target;
    logic                      i_branch_valid;
    logic                      i_output_ready;
    logic                      o_output_valid;
    fetch_pkg::fetch_bundle_t  o_bundle;

    // stimulus state
    logic [31:0]               lfsr;
    logic                      mem_busy;
    logic [`FETCH_VADDR_W-1:0] mem_addr;
    int                        lat_left;
    int                        br_wait;
    fetch_pkg::fetch_bundle_t  model_bundle;
    logic                      model_branch;
    logic [3:0]                model_adv;

    // compare state
    int                        sends = 0;
    logic                      first_cycle;
    logic                      pending;
    logic                      wait_strobe;
    logic                      stall;
    logic                      sent;
    logic                      exp_ren;
    logic                      exp_branch;
    logic [3:0]                exp_adv;
    logic [`FETCH_VADDR_W-1:0] exp_addr;
    logic [`FETCH_VADDR_W-1:0] last_addr;
    fetch_pkg::fetch_bundle_t  exp_bundle;
    fetch_pkg::fetch_bundle_t  stall_bundle;

    fetch_unit fetch_unit_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .o_mem_ren       (o_mem_ren),
        .o_mem_raddr     (o_mem_raddr),
        .i_mem_rdata     (i_mem_rdata),
        .i_mem_valid     (i_mem_valid),
        .i_branch_target (i_branch_target),
        .i_branch_valid  (i_branch_valid),
        .i_output_ready  (i_output_ready),
        .o_output_valid  (o_output_valid),
        .o_bundle        (o_bundle)
    );

    bind fetch_unit fetch_props fetch_props_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_ren      (o_mem_ren),
        .i_mem_valid    (i_mem_valid),
        .i_output_ready (i_output_ready),
        .i_output_valid (o_output_valid),
        .i_bundle       (o_bundle)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // galois form, taps 32 22 2 1, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // instruction memory contents, a hash of the full address
    function automatic logic [63:0] mem_word(input logic [`FETCH_VADDR_W-1:0] addr);
        logic [63:0] h;
        logic [63:0] w;
        logic [2:0]  kind;
        logic        wide;
        int          s1;
        int          base;
        h = {25'h0, addr} * 64'h9e37_79b9_7f4a_7c15;
        h = h ^ (h >> 29);
        h = h * 64'hbf58_476d_1ce4_e5b9;
        h = h ^ (h >> 32);
        w = h;
        kind = h[50:48];
        // slot 0 is an op-imm or a quadrant 0 halfword
        if (h[0]) begin
            w[6:0] = 7'b0010011;
            s1 = 32;
        end else begin
            w[1:0] = 2'b00;
            s1 = 16;
        end
        // slot 1 right behind it, an op or a quadrant 0 halfword
        if (h[1]) begin
            w[s1 +: 7] = 7'b0110011;
        end else begin
            w[s1 +: 2] = 2'b00;
        end
        // roughly one group in eight carries a jump or branch
        if (h[53:51] == 3'b000) begin
            base = h[47] ? s1 : 0;
            wide = h[47] ? h[1] : h[0];
            if (wide) begin
                case (kind)
                    3'd0, 3'd3, 3'd6: w[base +: 7] = `OPC_BRANCH;
                    3'd1, 3'd4, 3'd7: w[base +: 7] = `OPC_JAL;
                    default:          w[base +: 7] = `OPC_JALR;
                endcase
            end else begin
                w[base +: 2] = `RVC_Q1;
                case (kind)
                    3'd0: w[base + 13 +: 3] = `RVC_F3_J;
                    3'd1: w[base + 13 +: 3] = `RVC_F3_JAL;
                    3'd2: w[base + 13 +: 3] = `RVC_F3_BEQZ;
                    3'd3: w[base + 13 +: 3] = `RVC_F3_BNEZ;
                    default: begin
                        // c.jr or c.jalr, rs1 forced nonzero
                        w[base +: 2] = `RVC_Q2;
                        w[base + 13 +: 3] = `RVC_F3_JR;
                        w[base + 7 +: 5] = h[44:40] | 5'd1;
                        w[base + 2 +: 5] = 5'd0;
                    end
                endcase
            end
        end
        return w;
    endfunction

    function automatic logic slot_is_branch(input fetch_pkg::inst_u s, input logic c);
        logic hit;
        hit = 1'b0;
        if (!c) begin
            hit = s.full.opcode inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR};
        end else if (s.rvc.quadrant == `RVC_Q1) begin
            hit = s.rvc.funct3 inside {`RVC_F3_J, `RVC_F3_JAL, `RVC_F3_BEQZ, `RVC_F3_BNEZ};
        end else if (s.rvc.quadrant == `RVC_Q2) begin
            hit = (s.rvc.funct3 == `RVC_F3_JR) && (s.rvc.rs1 != 5'd0) && (s.rvc.rs2 == 5'd0);
        end
        return hit;
    endfunction

    // expected group, branch presence and pc step for one memory word
    function automatic void ref_group(
        input  logic [`FETCH_WORD_W-1:0] word,
        output fetch_pkg::fetch_bundle_t bundle,
        output logic                     any_branch,
        output logic [3:0]               adv
    );
        fetch_pkg::inst_u s0;
        fetch_pkg::inst_u s1;
        logic             c0;
        logic             c1;
        logic             b0;
        logic             b1;
        s0 = word[31:0];
        c0 = s0.rvc.quadrant != 2'b11;
        s1 = c0 ? word[47:16] : word[63:32];
        c1 = s1.rvc.quadrant != 2'b11;
        b0 = slot_is_branch(s0, c0);
        b1 = slot_is_branch(s1, c1);
        bundle.inst0 = s0;
        bundle.inst1 = s1;
        bundle.compressed = {c1, c0};
        bundle.count = !b0;
        any_branch = b0 || b1;
        if (b0) begin
            adv = c0 ? 4'd2 : 4'd4;
        end else begin
            adv = 4'd8 - {2'b00, c0, 1'b0} - {2'b00, c1, 1'b0};
        end
    endfunction

    task automatic check_eq(input string name, input logic [95:0] got, input logic [95:0] want);
        if (got !== want) begin
            $display("ERR %s got %h expected %h", name, got, want);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic finish_run;
        // last edge's assertions are done by the falling edge
        @(negedge i_clk);
        if (fetch_unit_inst.fetch_props_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_mem_rdata = '0;
        i_mem_valid = 1'b0;
        i_branch_target = '0;
        i_branch_valid = 1'b0;
        i_output_ready = 1'b0;
        lfsr = 32'hef92_2436;
        mem_busy = 1'b0;
        mem_addr = '0;
        lat_left = 0;
        br_wait = -1;
        last_addr = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
    end

    // memory, decode and branch unit models
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            i_mem_valid <= 1'b0;
            i_branch_valid <= 1'b0;
            i_output_ready <= rand_bits(1);
            // a sent group with a jump needs a resolved target later
            if (o_output_valid && i_output_ready) begin
                ref_group(i_mem_rdata, model_bundle, model_branch, model_adv);
                if (model_branch) begin
                    br_wait = rand_bits(2);
                end
            end
            if (br_wait >= 0) begin
                if (br_wait == 0) begin
                    i_branch_valid <= 1'b1;
                    i_branch_target <= `FETCH_RESET_ADDR + {rand_bits(18), 1'b0};
                end
                br_wait = br_wait - 1;
            end
            if (mem_busy) begin
                lat_left = lat_left - 1;
                if (lat_left == 0) begin
                    i_mem_valid <= 1'b1;
                    i_mem_rdata <= mem_word(mem_addr);
                    mem_busy = 1'b0;
                end
            end
            // read data stays on the bus until the next answer
            if (o_mem_ren) begin
                mem_addr = o_mem_raddr;
                lat_left = rand_bits(2);
                if (lat_left == 0) begin
                    i_mem_valid <= 1'b1;
                    i_mem_rdata <= mem_word(mem_addr);
                end else begin
                    mem_busy = 1'b1;
                end
            end
        end
    end

    // compare against the reference, one edge at a time
    always @(posedge i_clk) begin
        if (fetch_unit_inst.fetch_props_inst.fail_count != 0) begin
            // a bound assertion fired on an earlier edge
            $display("a protocol assertion in the bound checker failed");
            $display("Simulation finished: FAIL");
            $fatal(1, "protocol assertion failure");
        end else if (!i_rst_n) begin
            check_eq("o_mem_ren", o_mem_ren, 0);
            check_eq("o_output_valid", o_output_valid, 0);
            first_cycle = 1'b1;
            pending = 1'b0;
            wait_strobe = 1'b0;
            stall = 1'b0;
        end else begin
            sent = o_output_valid && i_output_ready;
            if (stall) begin
                check_eq("o_bundle", o_bundle, stall_bundle);
            end
            if (i_mem_valid) begin
                pending = 1'b1;
            end
            // valid from the answer until the group is taken
            check_eq("o_output_valid", o_output_valid, pending);
            exp_branch = 1'b0;
            exp_adv = 4'd0;
            if (pending) begin
                ref_group(mem_word(last_addr), exp_bundle, exp_branch, exp_adv);
                check_eq("o_bundle", o_bundle, exp_bundle);
            end
            // requests only at reset exit, on a jump-free send, or with the target
            // every send shows the stepped pc on the address, a jump too
            exp_ren = 1'b0;
            exp_addr = '0;
            if (first_cycle) begin
                exp_ren = 1'b1;
                exp_addr = `FETCH_RESET_ADDR;
            end else if (sent) begin
                exp_ren = !exp_branch;
                exp_addr = last_addr + exp_adv;
            end else if (wait_strobe && i_branch_valid) begin
                exp_ren = 1'b1;
                exp_addr = i_branch_target;
            end
            check_eq("o_mem_ren", o_mem_ren, exp_ren);
            if (exp_ren || sent) begin
                check_eq("o_mem_raddr", o_mem_raddr, exp_addr);
            end
            first_cycle = 1'b0;
            if (o_mem_ren) begin
                last_addr = o_mem_raddr;
            end
            if (wait_strobe && i_branch_valid) begin
                wait_strobe = 1'b0;
            end
            if (sent) begin
                pending = 1'b0;
                sends++;
                wait_strobe = exp_branch;
            end
            stall = o_output_valid && !i_output_ready;
            stall_bundle = o_bundle;
            if (sends == N_GROUPS) begin
                finish_run();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d groups were sent in time", sends, N_GROUPS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
